// ==== Makefile ====
TOP = tb_sdram_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== dv/sdram_ctrl_checker.sv ====
// Bound assertions on init order, latency, address mapping, bus ownership and refresh
`timescale 1ns/1ps

module sdram_ctrl_checker
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  seq_state_t         state,
    input  sdram_op_t          op,
    input  sdram_pins_t        pins,
    input  wire [DATA_W-1:0]   dq,
    input  logic               ready,
    input  logic [1:0]         cmd,
    input  logic [ADDR_W-1:0]  addr,
    input  logic [DATA_W-1:0]  wr_data,
    input  logic               valid
);

    localparam logic [3:0] C_NOP = 4'b0111;
    localparam logic [3:0] C_PRE = 4'b0010;
    localparam logic [3:0] C_REF = 4'b0001;
    localparam logic [3:0] C_LMR = 4'b0000;
    localparam logic [3:0] C_ACT = 4'b0011;
    localparam logic [3:0] C_RD  = 4'b0101;
    localparam logic [3:0] C_WR  = 4'b0100;

    int                fail_count = 0;
    logic [3:0]        cmd_bits;
    logic [ADDR_W-1:0] host_addr_q;
    logic [DATA_W-1:0] host_data_q;
    int                idle_run;
    logic              taken;

    assign cmd_bits   = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
    assign taken      = (state == IDLE) && ready;

    // Request as the host presented it
    always_ff @(posedge clk) begin
        if (taken) begin
            host_addr_q <= addr;
            host_data_q <= wr_data;
        end
        idle_run <= (!rst && state == IDLE) ? idle_run + 1 : 0;
    end

    a_reset_nop: assert property (@(posedge clk) rst && $past(rst) |->
        !valid && pins.cke && cmd_bits == C_NOP)
        else begin fail_count++; $error("command pins not NOP or valid high in reset"); end

    a_init_order: assert property (@(posedge clk) disable iff (rst)
        state == INIT_START |->
        ##2 (cmd_bits == C_PRE && pins.addr[AP_BIT])
        ##2 (cmd_bits == C_REF) ##3 (cmd_bits == C_REF)
        ##3 (cmd_bits == C_LMR && pins.addr == MODE_WORD) ##1 valid ##1 !valid)
        else begin fail_count++; $error("initialization sequence out of order"); end

    a_write_latency: assert property (@(posedge clk) disable iff (rst)
        taken && cmd == HOST_CMD_WRITE |-> ##1 !valid ##1 !valid ##1 !valid ##1 valid)
        else begin fail_count++; $error("write valid not 4 cycles after ready"); end

    a_read_latency: assert property (@(posedge clk) disable iff (rst)
        taken && cmd != HOST_CMD_WRITE |->
        ##1 !valid ##1 !valid ##1 !valid ##1 !valid ##1 valid)
        else begin fail_count++; $error("read valid not 5 cycles after ready"); end

    // Every valid belongs to init or to one sampled request
    a_valid_source: assert property (@(posedge clk) disable iff (rst)
        valid |-> state == INIT_DONE
            || $past(taken && cmd == HOST_CMD_WRITE, 4)
            || $past(taken && cmd != HOST_CMD_WRITE, 5))
        else begin fail_count++; $error("valid pulse without a matching request"); end

    a_active_addr: assert property (@(posedge clk) disable iff (rst)
        cmd_bits == C_ACT |-> pins.ba == host_addr_q[24:23] && pins.addr == host_addr_q[22:10])
        else begin fail_count++; $error("bank or row wrong in ACTIVE"); end

    a_col_addr: assert property (@(posedge clk) disable iff (rst)
        (cmd_bits == C_RD || cmd_bits == C_WR) |->
        pins.addr[9:0] == host_addr_q[9:0] && pins.addr[AP_BIT] && pins.addr[12:11] == 2'b00
        && pins.ba == host_addr_q[24:23])
        else begin fail_count++; $error("column address wrong in read or write"); end

    a_dqm: assert property (@(posedge clk) disable iff (rst)
        (pins.dqm == 2'b00) == (op == READ_AP || op == WRITE_AP) && pins.dqm != 2'b01
        && pins.dqm != 2'b10)
        else begin fail_count++; $error("dqm not low exactly in data commands"); end

    a_write_dq: assert property (@(posedge clk) disable iff (rst)
        cmd_bits == C_WR |-> dq == host_data_q)
        else begin fail_count++; $error("write data missing on the DQ bus"); end

    a_active_source: assert property (@(posedge clk) disable iff (rst)
        cmd_bits == C_ACT |-> $past(taken, 2))
        else begin fail_count++; $error("ACTIVE without an accepted request"); end

    a_refresh_gap: assert property (@(posedge clk) disable iff (rst)
        state == REF_SETUP |-> idle_run == REFRESH_IDLE_CYCLES)
        else begin fail_count++; $error("refresh started after the wrong idle stretch"); end

    a_refresh_on_time: assert property (@(posedge clk) disable iff (rst)
        state == IDLE && !ready && idle_run == REFRESH_IDLE_CYCLES - 1 |=> state == REF_SETUP)
        else begin fail_count++; $error("refresh did not start when due"); end

    a_refresh_seq: assert property (@(posedge clk) disable iff (rst)
        state == REF_SETUP |-> ##1 (cmd_bits == C_PRE && pins.addr[AP_BIT])
        ##2 (cmd_bits == C_REF) ##3 (cmd_bits == C_REF))
        else begin fail_count++; $error("refresh command sequence wrong"); end

    a_refresh_length: assert property (@(posedge clk) disable iff (rst)
        state == REF_SETUP |-> ##9 (state == IDLE))
        else begin fail_count++; $error("refresh did not last nine cycles"); end

endmodule

bind sdram_ctrl_top sdram_ctrl_checker u_chk (
    .clk     (clk),
    .rst     (rst),
    .state   (u_seq.state),
    .op      (op),
    .pins    ({dram_cke, dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n,
               dram_udqm, dram_ldqm, dram_ba, dram_addr}),
    .dq      (dram_dq),
    .ready   (ready),
    .cmd     (cmd),
    .addr    (addr),
    .wr_data (wr_data),
    .valid   (valid)
);

// ==== dv/sdram_model.sv ====
// Behavioral single-data-rate SDRAM with sparse store and CAS latency 2 read return
`timescale 1ns/1ps

module sdram_model
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               cke,
    input  logic               cs_n,
    input  logic               ras_n,
    input  logic               cas_n,
    input  logic               we_n,
    input  logic [1:0]         dqm,
    input  logic [BANK_W-1:0]  ba,
    input  logic [ROW_W-1:0]   addr,
    inout  wire [DATA_W-1:0]   dq
);

    logic [DATA_W-1:0] mem [int unsigned];
    logic [ROW_W-1:0]  open_row [4];
    logic [3:0]        cmd_bits;
    logic              rd_pend;
    logic [DATA_W-1:0] rd_word;
    logic              drive_en;
    logic [DATA_W-1:0] drive_val;
    int unsigned       wr_key;
    logic [DATA_W-1:0] wr_word;

    assign cmd_bits = {cs_n, ras_n, cas_n, we_n};
    assign dq = drive_en ? drive_val : {DATA_W{1'bz}};

    function automatic int unsigned word_key(input logic [BANK_W-1:0] b,
                                             input logic [ROW_W-1:0] r,
                                             input logic [COL_W-1:0] c);
        return int'({b, r, c});
    endfunction

    initial begin
        rd_pend   = 1'b0;
        rd_word   = '0;
        drive_en  = 1'b0;
        drive_val = '0;
    end

    always @(posedge clk) begin
        // Second stage of the CAS 2 pipeline puts the word on the bus
        drive_en  <= rd_pend;
        drive_val <= rd_word;
        rd_pend   <= 1'b0;
        if (cke) begin
            case (cmd_bits)
                4'b0011: open_row[ba] <= addr;
                4'b0100: begin
                    // Byte lanes with dqm high keep their old contents
                    wr_key  = word_key(ba, open_row[ba], addr[COL_W-1:0]);
                    wr_word = mem.exists(wr_key) ? mem[wr_key] : '0;
                    if (!dqm[0])
                        wr_word[7:0] = dq[7:0];
                    if (!dqm[1])
                        wr_word[DATA_W-1:8] = dq[DATA_W-1:8];
                    mem[wr_key] = wr_word;
                end
                4'b0101: begin
                    rd_pend <= 1'b1;
                    if (mem.exists(word_key(ba, open_row[ba], addr[COL_W-1:0])))
                        rd_word <= mem[word_key(ba, open_row[ba], addr[COL_W-1:0])];
                    else
                        rd_word <= 16'hdead;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== dv/tb_sdram_ctrl.sv ====
// Testbench top with clock, reset, random write/read stimulus, scoreboard and watchdog
`timescale 1ns/1ps

module tb_sdram_ctrl
    import sdram_pkg::*;
();

    localparam int NUM_WORDS      = 16;
    localparam int NUM_REQ        = 2 * NUM_WORDS + 4;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 20 + 2000;

    logic               clk;
    logic               rst;
    logic [1:0]         cmd;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  wr_data;
    logic               ready;
    logic               valid;
    logic [DATA_W-1:0]  rd_data;
    logic [ROW_W-1:0]   dram_addr;
    logic [BANK_W-1:0]  dram_ba;
    wire  [DATA_W-1:0]  dram_dq;
    logic               dram_ldqm;
    logic               dram_udqm;
    logic               dram_ras_n;
    logic               dram_cas_n;
    logic               dram_cke;
    logic               dram_clk;
    logic               dram_we_n;
    logic               dram_cs_n;

    logic [DATA_W-1:0]  sb [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0]  written [$];
    int                 read_errors = 0;

    sdram_ctrl_top dut (.*);

    sdram_model u_mem (
        .clk   (dram_clk),
        .cke   (dram_cke),
        .cs_n  (dram_cs_n),
        .ras_n (dram_ras_n),
        .cas_n (dram_cas_n),
        .we_n  (dram_we_n),
        .dqm   ({dram_udqm, dram_ldqm}),
        .ba    (dram_ba),
        .addr  (dram_addr),
        .dq    (dram_dq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One request, raised gap cycles into IDLE; stray adds an ignored ready mid-command
    task automatic send_request(input logic [1:0] c, input logic [ADDR_W-1:0] a,
                                input logic [DATA_W-1:0] d, input int gap,
                                input bit stray, output logic [DATA_W-1:0] got);
        repeat (gap + 1) @(negedge clk);
        cmd     = c;
        addr    = a;
        wr_data = d;
        ready   = 1'b1;
        @(negedge clk);
        ready = 1'b0;
        if (stray) begin
            @(negedge clk);
            cmd   = HOST_CMD_WRITE;
            ready = 1'b1;
            @(negedge clk);
            ready = 1'b0;
        end
        while (!valid) @(negedge clk);
        got = rd_data;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                              input int gap);
        logic [DATA_W-1:0] unused;
        send_request(HOST_CMD_WRITE, a, d, gap, 1'b0, unused);
        sb[a] = d;
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] a, input int gap, input bit stray);
        logic [DATA_W-1:0] got;
        send_request(HOST_CMD_READ, a, '0, gap, stray, got);
        assert (got == sb[a]) else begin
            read_errors++;
            $display("[FAIL] %0t rd_data got %h expected %h", $time, got, sb[a]);
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        void'($urandom(32'hc9f1e50f));
        rst     = 1'b1;
        ready   = 1'b0;
        cmd     = HOST_CMD_READ;
        addr    = '0;
        wr_data = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Init ends with its own valid pulse
        @(negedge clk);
        while (!valid) @(negedge clk);

        for (int i = 0; i < NUM_WORDS; i++) begin
            a = ADDR_W'($urandom());
            write_word(a, DATA_W'($urandom()), 0);
            written.push_back(a);
        end
        foreach (written[i]) begin
            check_read(written[i], 0, 1'b0);
        end
        check_read(written[0], 0, 1'b1);

        // Long idle lets a refresh run first
        a = ADDR_W'($urandom());
        write_word(a, DATA_W'($urandom()), 140);
        check_read(a, 0, 1'b0);
        // Ready lands in the refresh-due cycle
        check_read(written[1], 127, 1'b0);
        repeat (20) @(negedge clk);

        $display("Errors: read %0d, assertion %0d", read_errors, dut.u_chk.fail_count);
        if (read_errors == 0 && dut.u_chk.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== src/sdram_cmd_encoder.sv ====
// Opcode to SDRAM command pin encoder with bank, row and column address muxing
`timescale 1ns/1ps

module sdram_cmd_encoder
    import sdram_pkg::*;
(
    input  sdram_op_t    op,
    input  host_req_t    req,
    output sdram_pins_t  pins
);

    logic [ROW_W-1:0] col_addr;

    // A12 and A11 stay low, A10 asks for auto-precharge
    always_comb begin
        col_addr                = '0;
        col_addr[COL_W-1:0]     = req.col;
        col_addr[AP_BIT]        = 1'b1;
    end

    always_comb begin
        // NOP with data masked
        pins.cke   = 1'b1;
        pins.cs_n  = 1'b0;
        pins.ras_n = 1'b1;
        pins.cas_n = 1'b1;
        pins.we_n  = 1'b1;
        pins.dqm   = 2'b11;
        pins.ba    = '0;
        pins.addr  = '0;

        case (op)
            PRECHARGE_ALL: begin
                pins.ras_n        = 1'b0;
                pins.we_n         = 1'b0;
                pins.addr[AP_BIT] = 1'b1;
            end
            AUTO_REFRESH: begin
                pins.ras_n = 1'b0;
                pins.cas_n = 1'b0;
            end
            LOAD_MODE: begin
                pins.ras_n = 1'b0;
                pins.cas_n = 1'b0;
                pins.we_n  = 1'b0;
                pins.addr  = MODE_WORD;
            end
            ACTIVE: begin
                pins.ras_n = 1'b0;
                pins.ba    = req.bank;
                pins.addr  = req.row;
            end
            READ_AP: begin
                pins.cas_n = 1'b0;
                pins.dqm   = 2'b00;
                pins.ba    = req.bank;
                pins.addr  = col_addr;
            end
            WRITE_AP: begin
                pins.cas_n = 1'b0;
                pins.we_n  = 1'b0;
                pins.dqm   = 2'b00;
                pins.ba    = req.bank;
                pins.addr  = col_addr;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/sdram_ctrl_top.sv ====
// SDRAM controller top with request capture, sequencer, command encoder and data path
`timescale 1ns/1ps

module sdram_ctrl_top
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         cmd,
    input  logic [ADDR_W-1:0]  addr,
    input  logic [DATA_W-1:0]  wr_data,
    input  logic               ready,
    output logic               valid,
    output logic [DATA_W-1:0]  rd_data,

    output logic [ROW_W-1:0]   dram_addr,
    output logic [BANK_W-1:0]  dram_ba,
    inout  wire [DATA_W-1:0]   dram_dq,
    output logic               dram_ldqm,
    output logic               dram_udqm,
    output logic               dram_ras_n,
    output logic               dram_cas_n,
    output logic               dram_cke,
    output logic               dram_clk,
    output logic               dram_we_n,
    output logic               dram_cs_n
);

    logic         accept;
    logic         rd_sample;
    host_req_t    req;
    sdram_op_t    op;
    sdram_pins_t  pins;

    sdram_req_capture u_capture (
        .clk     (clk),
        .rst     (rst),
        .accept  (accept),
        .cmd     (cmd),
        .addr    (addr),
        .wr_data (wr_data),
        .req     (req)
    );

    sdram_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .req       (req),
        .accept    (accept),
        .op        (op),
        .rd_sample (rd_sample),
        .valid     (valid)
    );

    sdram_cmd_encoder u_enc (
        .op   (op),
        .req  (req),
        .pins (pins)
    );

    sdram_data_path u_data (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .rd_sample (rd_sample),
        .req       (req),
        .dq        (dram_dq),
        .rd_data   (rd_data)
    );

    // Chip pins
    assign dram_cke   = pins.cke;
    assign dram_cs_n  = pins.cs_n;
    assign dram_ras_n = pins.ras_n;
    assign dram_cas_n = pins.cas_n;
    assign dram_we_n  = pins.we_n;
    assign dram_ldqm  = pins.dqm[0];
    assign dram_udqm  = pins.dqm[1];
    assign dram_ba    = pins.ba;
    assign dram_addr  = pins.addr;

    // Chip runs on the controller clock
    assign dram_clk = clk;

endmodule

// ==== src/sdram_data_path.sv ====
// DQ bus driver for writes and read data capture and hold
`timescale 1ns/1ps

module sdram_data_path
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  sdram_op_t          op,
    input  logic               rd_sample,
    input  host_req_t          req,
    inout  wire [DATA_W-1:0]   dq,
    output logic [DATA_W-1:0]  rd_data
);

    logic [DATA_W-1:0] rd_hold;

    // Controller owns the bus only in the write command cycle
    assign dq = (op == WRITE_AP) ? req.wr_data : {DATA_W{1'bz}};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hold <= '0;
        end else if (rd_sample) begin
            rd_hold <= dq;
        end
    end

    // Live bus in the sample cycle, held word after it
    assign rd_data = rd_sample ? dq : rd_hold;

endmodule

// ==== src/sdram_pkg.sv ====
// Widths, timing constants, host codes, SDRAM opcodes, sequencer states and packed structs
package sdram_pkg;

    // Host side
    localparam int ADDR_W = 25;
    localparam int DATA_W = 16;

    // Chip geometry
    localparam int BANK_W = 2;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 10;

    // A10 selects auto-precharge or all banks
    localparam int AP_BIT = 10;

    // Timing
    localparam int CAS_LATENCY         = 2;
    localparam int REFRESH_IDLE_CYCLES = 128;
    localparam int REFRESH_CNT_W       = $clog2(REFRESH_IDLE_CYCLES);

    // Single-location write, CAS 2, interleaved, burst of one
    localparam logic [ROW_W-1:0] MODE_WORD = {
        3'b000,
        1'b1,
        2'b00,
        3'(CAS_LATENCY),
        1'b1,
        3'b000
    };

    // Host command codes
    localparam logic [1:0] HOST_CMD_READ  = 2'b01;
    localparam logic [1:0] HOST_CMD_WRITE = 2'b10;

    // Chip command for the current cycle
    typedef enum logic [2:0] {
        NOP,
        PRECHARGE_ALL,
        AUTO_REFRESH,
        LOAD_MODE,
        ACTIVE,
        READ_AP,
        WRITE_AP
    } sdram_op_t;

    typedef enum logic [4:0] {
        INIT_START,
        INIT_NOP0,
        INIT_PRECHARGE,
        INIT_NOP1,
        INIT_REF0,
        INIT_NOP2,
        INIT_NOP3,
        INIT_REF1,
        INIT_NOP4,
        INIT_NOP5,
        INIT_LOAD,
        INIT_DONE,
        RD_SETUP,
        RD_ACTIVE,
        RD_CMD,
        RD_WAIT,
        RD_DATA,
        WR_SETUP,
        WR_ACTIVE,
        WR_CMD,
        WR_DONE,
        REF_SETUP,
        REF_PRECHARGE,
        REF_NOP0,
        REF_AUTO0,
        REF_NOP1,
        REF_NOP2,
        REF_AUTO1,
        REF_NOP3,
        REF_END,
        IDLE
    } seq_state_t;

    // Request held for the whole command
    typedef struct packed {
        logic              write;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        logic [DATA_W-1:0] wr_data;
    } host_req_t;

    typedef struct packed {
        logic              cke;
        logic              cs_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic [1:0]        dqm;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  addr;
    } sdram_pins_t;

endpackage

// ==== src/sdram_req_capture.sv ====
// Host request register with address split into bank, row and column
`timescale 1ns/1ps

module sdram_req_capture
    import sdram_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,
    input  logic [1:0]          cmd,
    input  logic [ADDR_W-1:0]   addr,
    input  logic [DATA_W-1:0]   wr_data,
    output host_req_t           req
);

    // Write flag steers the sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            req.write <= 1'b0;
        end else if (accept) begin
            req.write <= (cmd == HOST_CMD_WRITE);
        end
    end

    // Bank 24:23, row 22:10, column 9:0
    always_ff @(posedge clk) begin
        if (accept) begin
            req.bank    <= addr[ADDR_W-1 -: BANK_W];
            req.row     <= addr[COL_W +: ROW_W];
            req.col     <= addr[COL_W-1:0];
            req.wr_data <= wr_data;
        end
    end

endmodule

// ==== src/sdram_sequencer.sv ====
// Command FSM with init, read, write and refresh paths plus idle refresh timer
`timescale 1ns/1ps

module sdram_sequencer
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ready,
    input  host_req_t  req,
    output logic       accept,
    output sdram_op_t  op,
    output logic       rd_sample,
    output logic       valid
);

    seq_state_t               state;
    seq_state_t               state_next;
    logic [REFRESH_CNT_W-1:0] refresh_cnt;
    logic                     refresh_due;

    assign refresh_due = (refresh_cnt == '0);
    assign accept      = (state == IDLE) && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= INIT_START;
            refresh_cnt <= REFRESH_CNT_W'(REFRESH_IDLE_CYCLES - 1);
        end else begin
            state <= state_next;
            // Counts only across an unbroken run of idle cycles
            if (state == IDLE) begin
                refresh_cnt <= refresh_cnt - 1'b1;
            end else begin
                refresh_cnt <= REFRESH_CNT_W'(REFRESH_IDLE_CYCLES - 1);
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            INIT_START:     state_next = INIT_NOP0;
            INIT_NOP0:      state_next = INIT_PRECHARGE;
            INIT_PRECHARGE: state_next = INIT_NOP1;
            INIT_NOP1:      state_next = INIT_REF0;
            INIT_REF0:      state_next = INIT_NOP2;
            INIT_NOP2:      state_next = INIT_NOP3;
            INIT_NOP3:      state_next = INIT_REF1;
            INIT_REF1:      state_next = INIT_NOP4;
            INIT_NOP4:      state_next = INIT_NOP5;
            INIT_NOP5:      state_next = INIT_LOAD;
            INIT_LOAD:      state_next = INIT_DONE;
            INIT_DONE:      state_next = IDLE;

            // Request lands in req here, so the read/write split happens now
            RD_SETUP:       state_next = req.write ? WR_ACTIVE : RD_ACTIVE;
            RD_ACTIVE:      state_next = RD_CMD;
            RD_CMD:         state_next = RD_WAIT;
            RD_WAIT:        state_next = RD_DATA;
            RD_DATA:        state_next = IDLE;

            WR_ACTIVE:      state_next = WR_CMD;
            WR_CMD:         state_next = WR_DONE;
            WR_DONE:        state_next = IDLE;

            REF_SETUP:      state_next = REF_PRECHARGE;
            REF_PRECHARGE:  state_next = REF_NOP0;
            REF_NOP0:       state_next = REF_AUTO0;
            REF_AUTO0:      state_next = REF_NOP1;
            REF_NOP1:       state_next = REF_NOP2;
            REF_NOP2:       state_next = REF_AUTO1;
            REF_AUTO1:      state_next = REF_NOP3;
            REF_NOP3:       state_next = REF_END;
            REF_END:        state_next = IDLE;

            IDLE: begin
                // A pending request beats a due refresh
                if (ready) begin
                    state_next = RD_SETUP;
                end else if (refresh_due) begin
                    state_next = REF_SETUP;
                end
            end

            default:        state_next = IDLE;
        endcase
    end

    always_comb begin
        case (state)
            INIT_PRECHARGE,
            REF_PRECHARGE:  op = PRECHARGE_ALL;
            INIT_REF0,
            INIT_REF1,
            REF_AUTO0,
            REF_AUTO1:      op = AUTO_REFRESH;
            INIT_LOAD:      op = LOAD_MODE;
            RD_ACTIVE,
            WR_ACTIVE:      op = ACTIVE;
            RD_CMD:         op = READ_AP;
            WR_CMD:         op = WRITE_AP;
            default:        op = NOP;
        endcase
    end

    assign valid     = (state == INIT_DONE) || (state == RD_DATA) || (state == WR_DONE);
    assign rd_sample = (state == RD_DATA);

endmodule

// ==== verilog.f ====
src/sdram_pkg.sv
src/sdram_req_capture.sv
src/sdram_sequencer.sv
src/sdram_cmd_encoder.sv
src/sdram_data_path.sv
src/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/sdram_ctrl_checker.sv
dv/tb_sdram_ctrl.sv
